// ==== include/warp_defines.svh ====
`ifndef WARP_DEFINES_SVH
`define WARP_DEFINES_SVH

// core geometry
`define NUM_WARPS       4
`define NUM_THREADS     4
`define NUM_BARRIERS    4

// divergence stack entries per warp
`define IPDOM_DEPTH     8

// instruction uuid width
`define UUID_BITS       16

// busy-cycle counter width
`define PERF_BITS       32

// all-stalled cycles tolerated before the scheduler is considered hung
`define STALL_TIMEOUT   1000

`endif

// ==== hw/warp_types_pkg.sv ====
`include "warp_defines.svh"

package warp_types_pkg;

    typedef logic [$clog2(`NUM_WARPS)-1:0] wid_t;
    typedef logic [`NUM_THREADS-1:0]        tmask_t;

    typedef struct packed {
        logic   valid;
        tmask_t tmask;
    } tmc_t;

    typedef struct packed {
        logic                  valid;
        logic [`NUM_WARPS-1:0] wmask;
        logic [31:0]           pc;
    } wspawn_t;

    // else pc only, the then path falls through
    typedef struct packed {
        logic        valid;
        logic        diverged;
        tmask_t      then_tmask;
        tmask_t      else_tmask;
        logic [31:0] pc;
    } split_t;

    typedef struct packed {
        logic                             valid;
        logic [$clog2(`NUM_BARRIERS)-1:0] id;
        wid_t                             size_m1;
    } barrier_t;

    typedef struct packed {
        logic     valid;
        wid_t     wid;
        tmc_t     tmc;
        wspawn_t  wspawn;
        split_t   split;
        barrier_t barrier;
    } warp_ctl_t;

    typedef struct packed {
        logic        valid;
        wid_t        wid;
        logic        taken;
        logic [31:0] dest;
    } branch_t;

    typedef struct packed {
        logic valid;
        wid_t wid;
    } wrelease_t;

    typedef struct packed {
        logic valid;
        wid_t wid;
    } join_t;

    typedef struct packed {
        logic       valid;
        logic [3:0] committed;
    } commit_t;

    typedef struct packed {
        logic [`UUID_BITS-1:0] uuid;
        wid_t                  wid;
        tmask_t                tmask;
        logic [31:0]           pc;
    } fetch_req_t;

    typedef struct packed {
        logic [31:0] pc;
        tmask_t      tmask;
    } stack_entry_t;

endpackage

// ==== hw/ipdom_stack.sv ====
`timescale 1ns/1ps
`include "warp_defines.svh"

module ipdom_stack
    import warp_types_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         push,
    input  logic         pop,
    input  logic         pair,
    input  stack_entry_t q1,
    input  stack_entry_t q2,
    output stack_entry_t d,
    output logic         second,
    output logic         empty,
    output logic         full
);

    localparam int DEPTH = `IPDOM_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);
    localparam int PTR_W = $clog2(DEPTH + 1);

    stack_entry_t     entries [DEPTH];
    logic [DEPTH-1:0] second_flags;
    logic [PTR_W-1:0] ptr;
    logic [IDX_W-1:0] top_idx;

    assign top_idx = IDX_W'(ptr - 1'b1);
    assign d       = entries[top_idx];
    assign second  = second_flags[top_idx];
    assign empty   = (ptr == '0);
    // no room left for a diverged pair
    assign full    = (ptr > PTR_W'(DEPTH - 2));

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (push) begin
            ptr <= pair ? ptr + PTR_W'(2) : ptr + PTR_W'(1);
        end else if (pop) begin
            ptr <= ptr - PTR_W'(1);
        end
    end

    // end entry goes first, else entry lands on top
    always_ff @(posedge clk) begin
        if (push) begin
            entries[IDX_W'(ptr)]      <= q1;
            second_flags[IDX_W'(ptr)] <= 1'b0;
            if (pair) begin
                entries[IDX_W'(ptr + 1'b1)]      <= q2;
                second_flags[IDX_W'(ptr + 1'b1)] <= 1'b1;
            end
        end
    end

    // split nesting must stay within the stack depth
    assert property (@(posedge clk) disable iff (reset) push |-> !full)
        else $error("%t: ipdom stack overflow", $time);

    // every join has a matching split
    assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
        else $error("%t: ipdom stack underflow", $time);

endmodule

// ==== hw/barrier_unit.sv ====
`timescale 1ns/1ps
`include "warp_defines.svh"

module barrier_unit
    import warp_types_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  warp_ctl_t             warp_ctl,
    output logic [`NUM_WARPS-1:0] barrier_stalls,
    output logic                  barrier_release
);

    localparam int CNT_W = $clog2(`NUM_WARPS + 1);

    logic [`NUM_BARRIERS-1:0][`NUM_WARPS-1:0] wait_masks;
    logic [`NUM_WARPS-1:0]                    cur_mask;
    logic [CNT_W-1:0]                         wait_count;
    logic                                     arrive;

    assign arrive   = warp_ctl.valid && warp_ctl.barrier.valid;
    assign cur_mask = wait_masks[warp_ctl.barrier.id];

    // warps already waiting, the arriving one is not yet counted
    always_comb begin
        wait_count = '0;
        for (int i = 0; i < `NUM_WARPS; i++) begin
            wait_count = wait_count + CNT_W'(cur_mask[i]);
        end
    end

    assign barrier_release = arrive && (wait_count == CNT_W'(warp_ctl.barrier.size_m1));

    always_ff @(posedge clk) begin
        if (reset) begin
            wait_masks <= '0;
        end else if (arrive) begin
            if (barrier_release) begin
                wait_masks[warp_ctl.barrier.id] <= '0;
            end else begin
                wait_masks[warp_ctl.barrier.id][warp_ctl.wid] <= 1'b1;
            end
        end
    end

    always_comb begin
        barrier_stalls = '0;
        for (int b = 0; b < `NUM_BARRIERS; b++) begin
            barrier_stalls = barrier_stalls | wait_masks[b];
        end
    end

    // a waiting warp is held and cannot arrive twice
    assert property (@(posedge clk) disable iff (reset)
        arrive |-> !cur_mask[warp_ctl.wid])
        else $error("%t: warp %0d arrived twice at barrier %0d",
                    $time, warp_ctl.wid, warp_ctl.barrier.id);

endmodule

// ==== hw/fetch_req_buffer.sv ====
`timescale 1ns/1ps

module fetch_req_buffer
    import warp_types_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid,
    output logic       in_ready,
    input  fetch_req_t in_req,
    output logic       out_valid,
    input  logic       out_ready,
    output fetch_req_t out_req,
    output logic       fire
);

    logic       valid_q;
    fetch_req_t req_q;

    // refill in the cycle the old entry drains
    assign in_ready  = !valid_q || out_ready;
    assign out_valid = valid_q;
    assign out_req   = req_q;
    assign fire      = valid_q && out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (in_valid && in_ready) begin
            valid_q <= 1'b1;
        end else if (out_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            req_q <= in_req;
        end
    end

    // stalled request is neither dropped nor changed
    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_req))
        else $error("%t: fetch request changed under back-pressure", $time);

endmodule

// ==== hw/warp_sched.sv ====
`timescale 1ns/1ps
`include "warp_defines.svh"

module warp_sched
    import warp_types_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [31:0]           startup_addr,
    input  warp_ctl_t             warp_ctl,
    input  wrelease_t             wrelease,
    input  join_t                 join_req,
    input  branch_t               branch,
    input  commit_t               commit,
    output logic                  sched_valid,
    input  logic                  sched_ready,
    output fetch_req_t            sched_req,
    input  logic                  fetch_fire,
    input  fetch_req_t            fired_req,
    output logic [`PERF_BITS-1:0] cycles,
    output logic                  busy
);

    localparam int PEND_W = 8;
    localparam int TO_W   = $clog2(`STALL_TIMEOUT + 1) + 1;

    logic [`NUM_WARPS-1:0]                       active_warps;
    logic [`NUM_WARPS-1:0]                       active_warps_n;
    logic [`NUM_WARPS-1:0]                       stalled_warps;
    logic [`NUM_WARPS-1:0]                       use_wspawn;
    logic [`NUM_WARPS-1:0]                       ready_warps;
    logic [`NUM_WARPS-1:0]                       barrier_stalls;
    logic [`NUM_WARPS-1:0][`NUM_THREADS-1:0]     thread_masks;
    logic [`NUM_WARPS-1:0][31:0]                 warp_pcs;
    logic [`NUM_WARPS-1:0][`UUID_BITS-1:0]       issued;
    logic [31:0]                                 wspawn_pc;
    logic                                        barrier_release;

    stack_entry_t                                stack_d [`NUM_WARPS];
    logic [`NUM_WARPS-1:0]                       stack_second;
    stack_entry_t                                q_end;
    stack_entry_t                                q_else;

    wid_t                                        sel_wid;
    logic                                        sched_fire;
    logic                                        ctl_tmc;
    logic                                        ctl_wspawn;
    logic                                        ctl_split;
    logic                                        ctl_barrier;
    logic [PEND_W-1:0]                           pending;
    logic [TO_W-1:0]                             timeout_ctr;
    logic                                        timeout_enable;

    assign ctl_tmc     = warp_ctl.valid && warp_ctl.tmc.valid;
    assign ctl_wspawn  = warp_ctl.valid && warp_ctl.wspawn.valid;
    assign ctl_split   = warp_ctl.valid && warp_ctl.split.valid;
    assign ctl_barrier = warp_ctl.valid && warp_ctl.barrier.valid;

    always_comb begin
        active_warps_n = active_warps;
        if (ctl_wspawn) begin
            active_warps_n = warp_ctl.wspawn.wmask;
        end
        if (ctl_tmc) begin
            active_warps_n[warp_ctl.wid] = (warp_ctl.tmc.tmask != '0);
        end
    end

    barrier_unit u_barrier (
        .clk             (clk),
        .reset           (reset),
        .warp_ctl        (warp_ctl),
        .barrier_stalls  (barrier_stalls),
        .barrier_release (barrier_release)
    );

    // the end entry only needs the mask to restore
    assign q_end.pc     = '0;
    assign q_end.tmask  = thread_masks[warp_ctl.wid];
    assign q_else.pc    = warp_ctl.split.pc;
    assign q_else.tmask = warp_ctl.split.else_tmask;

    for (genvar i = 0; i < `NUM_WARPS; i++) begin : g_ipdom
        ipdom_stack u_stack (
            .clk    (clk),
            .reset  (reset),
            .push   (ctl_split && (warp_ctl.wid == wid_t'(i))),
            .pop    (join_req.valid && (join_req.wid == wid_t'(i))),
            .pair   (warp_ctl.split.diverged),
            .q1     (q_end),
            .q2     (q_else),
            .d      (stack_d[i]),
            .second (stack_second[i]),
            .empty  (),
            .full   ()
        );
    end

    assign ready_warps = active_warps & ~(stalled_warps | barrier_stalls);
    assign sched_valid = (ready_warps != '0);
    assign sched_fire  = sched_valid && sched_ready;

    // lowest index wins
    always_comb begin
        sel_wid = '0;
        for (int i = `NUM_WARPS - 1; i >= 0; i--) begin
            if (ready_warps[i]) begin
                sel_wid = wid_t'(i);
            end
        end
    end

    assign sched_req.uuid  = `UUID_BITS'(issued[sel_wid] * `NUM_WARPS + sel_wid);
    assign sched_req.wid   = sel_wid;
    assign sched_req.tmask = use_wspawn[sel_wid] ? tmask_t'(1) : thread_masks[sel_wid];
    assign sched_req.pc    = use_wspawn[sel_wid] ? wspawn_pc : warp_pcs[sel_wid];

    always_ff @(posedge clk) begin
        if (reset) begin
            active_warps    <= '0;
            active_warps[0] <= 1'b1;
            stalled_warps   <= '0;
            use_wspawn      <= '0;
            thread_masks    <= '0;
            thread_masks[0] <= tmask_t'(1);
            warp_pcs        <= '0;
            warp_pcs[0]     <= startup_addr;
        end else begin
            if (join_req.valid) begin
                if (stack_second[join_req.wid]) begin
                    warp_pcs[join_req.wid] <= stack_d[join_req.wid].pc;
                end
                thread_masks[join_req.wid] <= stack_d[join_req.wid].tmask;
            end

            // warp 0 is the spawner and keeps its own pc
            if (ctl_wspawn) begin
                use_wspawn <= warp_ctl.wspawn.wmask & ~`NUM_WARPS'(1);
            end

            if (ctl_barrier) begin
                stalled_warps[warp_ctl.wid] <= 1'b0;
            end

            if (ctl_tmc) begin
                thread_masks[warp_ctl.wid]  <= warp_ctl.tmc.tmask;
                stalled_warps[warp_ctl.wid] <= 1'b0;
            end

            if (ctl_split) begin
                stalled_warps[warp_ctl.wid] <= 1'b0;
                if (warp_ctl.split.diverged) begin
                    thread_masks[warp_ctl.wid] <= warp_ctl.split.then_tmask;
                end
            end

            if (branch.valid) begin
                if (branch.taken) begin
                    warp_pcs[branch.wid] <= branch.dest;
                end
                stalled_warps[branch.wid] <= 1'b0;
            end

            // held until decode lets it go
            if (sched_fire) begin
                stalled_warps[sel_wid] <= 1'b1;
                if (use_wspawn[sel_wid]) begin
                    thread_masks[sel_wid] <= tmask_t'(1);
                end
                use_wspawn[sel_wid] <= 1'b0;
            end

            if (fetch_fire) begin
                warp_pcs[fired_req.wid] <= fired_req.pc + 32'd4;
            end

            if (wrelease.valid) begin
                stalled_warps[wrelease.wid] <= 1'b0;
            end

            active_warps <= active_warps_n;
        end
    end

    always_ff @(posedge clk) begin
        if (ctl_wspawn) begin
            wspawn_pc <= warp_ctl.wspawn.pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            issued  <= '0;
            pending <= '0;
            busy    <= 1'b1;
            cycles  <= '0;
        end else begin
            if (sched_fire) begin
                issued[sel_wid] <= issued[sel_wid] + 1'b1;
            end
            pending <= pending + PEND_W'(sched_fire)
                     - (commit.valid ? PEND_W'(commit.committed) : '0);
            busy    <= (active_warps != '0) || (pending != '0);
            if (busy) begin
                cycles <= cycles + 1'b1;
            end
        end
    end

    // armed by the first release from decode
    always_ff @(posedge clk) begin
        if (reset) begin
            timeout_ctr    <= '0;
            timeout_enable <= 1'b0;
        end else begin
            if (wrelease.valid) begin
                timeout_enable <= 1'b1;
            end
            if (barrier_release || active_warps == '0 || ready_warps != '0) begin
                timeout_ctr <= '0;
            end else if (timeout_enable) begin
                timeout_ctr <= timeout_ctr + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) timeout_ctr < TO_W'(`STALL_TIMEOUT))
        else $error("%t: scheduler timeout, stalled=%b barrier=%b",
                    $time, stalled_warps, barrier_stalls);

endmodule

// ==== hw/warp_fetch_top.sv ====
`timescale 1ns/1ps
`include "warp_defines.svh"

module warp_fetch_top
    import warp_types_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [31:0]           startup_addr,
    input  warp_ctl_t             warp_ctl,
    input  wrelease_t             wrelease,
    input  join_t                 join_req,
    input  branch_t               branch,
    input  commit_t               commit,
    output logic                  fetch_valid,
    input  logic                  fetch_ready,
    output fetch_req_t            fetch_req,
    output logic [`PERF_BITS-1:0] cycles,
    output logic                  busy
);

    logic       sched_valid;
    logic       sched_ready;
    fetch_req_t sched_req;
    logic       fetch_fire;

    warp_sched u_sched (
        .clk          (clk),
        .reset        (reset),
        .startup_addr (startup_addr),
        .warp_ctl     (warp_ctl),
        .wrelease     (wrelease),
        .join_req     (join_req),
        .branch       (branch),
        .commit       (commit),
        .sched_valid  (sched_valid),
        .sched_ready  (sched_ready),
        .sched_req    (sched_req),
        .fetch_fire   (fetch_fire),
        .fired_req    (fetch_req),
        .cycles       (cycles),
        .busy         (busy)
    );

    // registered valid/ready toward the icache
    fetch_req_buffer u_buf (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (sched_valid),
        .in_ready  (sched_ready),
        .in_req    (sched_req),
        .out_valid (fetch_valid),
        .out_ready (fetch_ready),
        .out_req   (fetch_req),
        .fire      (fetch_fire)
    );

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // held for 16 rising edges
    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// ==== tests/warp_fetch_tb.sv ====
`timescale 1ns/1ps
`include "warp_defines.svh"

module warp_fetch_tb
    import warp_types_pkg::*;
();

    logic                  clk;
    logic                  reset;
    logic [31:0]           startup_addr;
    warp_ctl_t             warp_ctl;
    wrelease_t             wrelease;
    join_t                 join_req;
    branch_t               branch;
    commit_t               commit;
    logic                  fetch_valid;
    logic                  fetch_ready;
    fetch_req_t            fetch_req;
    logic [`PERF_BITS-1:0] cycles;
    logic                  busy;

    // reference model of warp state
    logic [31:0]           exp_pc [`NUM_WARPS];
    tmask_t                exp_mask [`NUM_WARPS];
    int                    exp_issued [`NUM_WARPS];
    logic [`NUM_WARPS-1:0] exp_active;
    stack_entry_t          model_stack [$];
    logic                  model_second [$];

    fetch_req_t xfer_log [64];
    int         xfer_wr;
    int         xfer_rd;
    int         errors;
    int         test_errs;
    int         tests_run;
    int         tests_failed;
    int         seed;

    tb_clock u_clock (.clk(clk), .reset(reset));

    warp_fetch_top dut (
        .clk          (clk),
        .reset        (reset),
        .startup_addr (startup_addr),
        .warp_ctl     (warp_ctl),
        .wrelease     (wrelease),
        .join_req     (join_req),
        .branch       (branch),
        .commit       (commit),
        .fetch_valid  (fetch_valid),
        .fetch_ready  (fetch_ready),
        .fetch_req    (fetch_req),
        .cycles       (cycles),
        .busy         (busy)
    );

    // random back-pressure
    initial begin
        seed        = 47;
        fetch_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1 fetch_ready = 1'($random(seed));
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            xfer_wr <= 0;
        end else if (fetch_valid && fetch_ready) begin
            xfer_log[xfer_wr % 64] <= fetch_req;
            xfer_wr                <= xfer_wr + 1;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        fetch_valid && fetch_ready |-> fetch_req.pc == exp_pc[fetch_req.wid])
        else begin
            $display("mismatch at %0t: fetch_req.pc expected %h got %h",
                     $time, exp_pc[$sampled(fetch_req.wid)], $sampled(fetch_req.pc));
            errors++;
        end

    assert property (@(posedge clk) disable iff (reset)
        fetch_valid && fetch_ready |-> fetch_req.tmask == exp_mask[fetch_req.wid])
        else begin
            $display("mismatch at %0t: fetch_req.tmask expected %b got %b",
                     $time, exp_mask[$sampled(fetch_req.wid)], $sampled(fetch_req.tmask));
            errors++;
        end

    assert property (@(posedge clk) disable iff (reset)
        fetch_valid && fetch_ready |-> exp_active[fetch_req.wid])
        else begin
            $display("warp %0d was fetched at %0t while it should be inactive",
                     $sampled(fetch_req.wid), $time);
            errors++;
        end

    assert property (@(posedge clk) disable iff (reset)
        fetch_valid && !fetch_ready |=> fetch_valid && $stable(fetch_req))
        else begin
            $display("mismatch at %0t: fetch_req expected %h got %h",
                     $time, $past(fetch_req), $sampled(fetch_req));
            errors++;
        end

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (reset && n < 100) begin
            @(posedge clk);
            n++;
        end
        if (reset) begin
            $display("timed out waiting for reset to be released");
            $display("tests failed");
            $finish;
        end
    endtask

    task automatic drive_ctl(input warp_ctl_t ctl);
        warp_ctl = ctl;
        @(posedge clk);
        #1 warp_ctl = '0;
    endtask

    task automatic pulse_wrelease(input wid_t w);
        wrelease.valid = 1'b1;
        wrelease.wid   = w;
        @(posedge clk);
        #1 wrelease = '0;
    endtask

    task automatic pulse_branch(input wid_t w, input logic taken, input logic [31:0] dest);
        branch.valid = 1'b1;
        branch.wid   = w;
        branch.taken = taken;
        branch.dest  = dest;
        if (taken) begin
            exp_pc[w] = dest;
        end
        @(posedge clk);
        #1 branch = '0;
    endtask

    // join on warp 0 together with a release
    task automatic join_and_release();
        join_req.valid = 1'b1;
        join_req.wid   = '0;
        wrelease.valid = 1'b1;
        wrelease.wid   = '0;
        if (model_second[$]) begin
            exp_pc[0] = model_stack[$].pc;
        end
        exp_mask[0] = model_stack[$].tmask;
        void'(model_stack.pop_back());
        void'(model_second.pop_back());
        @(posedge clk);
        #1;
        join_req = '0;
        wrelease = '0;
    endtask

    task automatic next_transfer(input wid_t exp_wid);
        fetch_req_t            r;
        int                    n;
        logic [`UUID_BITS-1:0] exp_uuid;
        n = 0;
        while (xfer_rd == xfer_wr && n < 200) begin
            @(posedge clk);
            #1 n++;
        end
        if (xfer_rd == xfer_wr) begin
            $display("timed out waiting for a fetch transfer of warp %0d", exp_wid);
            $display("tests failed");
            $finish;
        end else begin
            r = xfer_log[xfer_rd % 64];
            xfer_rd++;
            exp_pc[r.wid] = exp_pc[r.wid] + 32'd4;
            // per-warp issue count spread by warp index
            exp_uuid = `UUID_BITS'(exp_issued[r.wid] * `NUM_WARPS + int'(r.wid));
            exp_issued[r.wid]++;
            assert (r.wid == exp_wid) else begin
                $display("mismatch at %0t: fetch_req.wid expected %0d got %0d",
                         $time, exp_wid, r.wid);
                errors++;
            end
            assert (r.uuid == exp_uuid) else begin
                $display("mismatch at %0t: fetch_req.uuid expected %0d got %0d",
                         $time, exp_uuid, r.uuid);
                errors++;
            end
        end
    endtask

    task automatic quiet_for(input int n);
        int start;
        start = xfer_wr;
        repeat (n) @(posedge clk);
        #1;
        assert (xfer_wr == start) else begin
            $display("a fetch transfer happened at %0t while all warps were held", $time);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_errs) begin
            tests_failed++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: ok", name);
        end
        test_errs = errors;
    endtask

    initial begin
        warp_ctl_t ctl;
        int        left;
        int        n;
        startup_addr = 32'h0000_1000;
        warp_ctl     = '0;
        wrelease     = '0;
        join_req     = '0;
        branch       = '0;
        commit       = '0;
        xfer_rd      = 0;
        errors       = 0;
        test_errs    = 0;
        tests_run    = 0;
        tests_failed = 0;
        exp_active   = 4'b0001;
        for (int i = 0; i < `NUM_WARPS; i++) begin
            exp_pc[i]     = '0;
            exp_mask[i]   = '0;
            exp_issued[i] = 0;
        end
        exp_pc[0]   = 32'h0000_1000;
        exp_mask[0] = tmask_t'(1);
        wait_reset_release();
        @(posedge clk);
        #1;

        next_transfer(0);
        pulse_wrelease(0);
        next_transfer(0);
        end_test("reset and sequential fetch");

        pulse_branch(0, 1'b1, 32'h0000_2000);
        next_transfer(0);
        pulse_branch(0, 1'b0, 32'h0000_7000);
        next_transfer(0);
        end_test("branch");

        ctl = '0;
        ctl.valid        = 1'b1;
        ctl.wspawn.valid = 1'b1;
        ctl.wspawn.wmask = 4'b1111;
        ctl.wspawn.pc    = 32'h0000_3000;
        exp_active = 4'b1111;
        for (int i = 1; i < `NUM_WARPS; i++) begin
            exp_pc[i]   = 32'h0000_3000;
            exp_mask[i] = tmask_t'(1);
        end
        drive_ctl(ctl);
        next_transfer(1);
        next_transfer(2);
        next_transfer(3);
        // two warps freed on the same edge
        wrelease.valid = 1'b1;
        wrelease.wid   = 2;
        pulse_branch(1, 1'b0, 32'h0);
        wrelease = '0;
        next_transfer(1);
        next_transfer(2);
        end_test("wspawn and priority");

        ctl = '0;
        ctl.valid     = 1'b1;
        ctl.tmc.valid = 1'b1;
        ctl.tmc.tmask = 4'b1111;
        exp_mask[0]   = 4'b1111;
        drive_ctl(ctl);
        next_transfer(0);
        ctl = '0;
        ctl.valid            = 1'b1;
        ctl.split.valid      = 1'b1;
        ctl.split.diverged   = 1'b1;
        ctl.split.then_tmask = 4'b0011;
        ctl.split.else_tmask = 4'b1100;
        ctl.split.pc         = 32'h0000_5000;
        model_stack.push_back('{pc: 32'h0, tmask: exp_mask[0]});
        model_second.push_back(1'b0);
        model_stack.push_back('{pc: 32'h0000_5000, tmask: 4'b1100});
        model_second.push_back(1'b1);
        exp_mask[0] = 4'b0011;
        drive_ctl(ctl);
        next_transfer(0);
        join_and_release();
        next_transfer(0);
        join_and_release();
        next_transfer(0);
        end_test("split and join");

        ctl = '0;
        ctl.valid           = 1'b1;
        ctl.barrier.valid   = 1'b1;
        ctl.barrier.id      = 1;
        ctl.barrier.size_m1 = 2;
        ctl.wid = 1;
        drive_ctl(ctl);
        ctl.wid = 2;
        drive_ctl(ctl);
        quiet_for(12);
        ctl.wid = 3;
        drive_ctl(ctl);
        next_transfer(1);
        next_transfer(2);
        next_transfer(3);
        end_test("barrier");

        ctl = '0;
        ctl.valid     = 1'b1;
        ctl.tmc.valid = 1'b1;
        ctl.tmc.tmask = '0;
        for (int i = 0; i < `NUM_WARPS; i++) begin
            ctl.wid       = wid_t'(i);
            exp_active[i] = 1'b0;
            drive_ctl(ctl);
        end
        quiet_for(20);
        // fetched requests are still uncommitted here
        assert (busy) else begin
            $display("busy was low at %0t while fetched requests were uncommitted", $time);
            errors++;
        end
        left = xfer_rd;
        while (left > 0) begin
            commit.valid     = 1'b1;
            commit.committed = (left > 15) ? 4'd15 : 4'(left);
            left             = left - int'(commit.committed);
            @(posedge clk);
            #1 commit = '0;
        end
        n = 0;
        while (busy && n < 100) begin
            @(posedge clk);
            #1 n++;
        end
        if (busy) begin
            $display("timed out waiting for busy to fall");
            $display("tests failed");
            $finish;
        end else begin
            assert (cycles >= `PERF_BITS'(xfer_rd)) else begin
                $display("mismatch at %0t: cycles expected at least %0d got %0d",
                         $time, xfer_rd, cycles);
                errors++;
            end
            end_test("tmc stop and busy");
            $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
            if (tests_failed == 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
            $finish;
        end
    end

endmodule

// ==== all.f ====
+incdir+include
hw/warp_types_pkg.sv
hw/ipdom_stack.sv
hw/barrier_unit.sv
hw/fetch_req_buffer.sv
hw/warp_sched.sv
hw/warp_fetch_top.sv
tests/tb_clock.sv
tests/warp_fetch_tb.sv

// ==== Makefile ====
SRCS := $(wildcard hw/*.sv tests/*.sv include/*.svh)

.PHONY: run clean

obj_dir/Vwarp_fetch_tb: $(SRCS) all.f
	verilator --binary --timing --assert -f all.f --top-module warp_fetch_tb -o Vwarp_fetch_tb

sim.log: obj_dir/Vwarp_fetch_tb
	./obj_dir/Vwarp_fetch_tb > sim.log 2>&1 || true

run: sim.log
	cat sim.log
	! grep -q "tests failed" sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
